/* include/avionics_defines.svh */
// Board clock, channel and PWM constants
// Arm gesture thresholds and APB register map
`ifndef AVIONICS_DEFINES_SVH
`define AVIONICS_DEFINES_SVH

// 8 MHz board clock
`define AV_CLK_PER_US   8
`define AV_US_PER_MS    1000
`define AV_MS_PER_10HZ  100

// Radio and ESC channels
`define AV_NUM_CH       8
`define AV_PWM_MAX_US   2047
`define AV_ESC_FRAME_US 2500

// Stick gesture: throttle low, yaw high
`define AV_ARM_THR_MAX  1100
`define AV_ARM_YAW_MIN  1900
`define AV_THR_CH       2
`define AV_YAW_CH       3

// APB bus widths and byte addresses
`define AV_APB_AW       8
`define AV_APB_DW       32
`define AV_ADDR_STATUS  8'h00
`define AV_ADDR_TIME    8'h04
`define AV_ADDR_CTRL    8'h08
`define AV_ADDR_RADIO0  8'h10

`endif

/* source/avionics_pkg.sv */
// Shared board types
// Board state encoding and pulse width in microseconds
`include "avionics_defines.svh"

package avionics_pkg;

  // Board controller states
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    STARTUP  = 2'd1,
    RUNNING  = 2'd2,
    SHUTDOWN = 2'd3
  } board_state_e;

  // Width wide enough for the saturation value
  typedef logic [$clog2(`AV_PWM_MAX_US + 1)-1:0] pulse_us_t;

endpackage

/* source/board_status_if.sv */
// Status link between board controller and APB registers
`include "avionics_defines.svh"

interface board_status_if;

  // Current board state
  avionics_pkg::board_state_e state;
  // Motors armed
  logic armed;
  // Milliseconds since entering RUNNING
  logic [23:0] timestamp;
  // One-cycle request from the host
  logic shutdown_req;

  // Controller side
  modport ctrl (
    output state,
    output armed,
    output timestamp,
    input  shutdown_req
  );

  // Register side
  modport regs (
    input  state,
    input  armed,
    input  timestamp,
    output shutdown_req
  );

endinterface

/* source/tick_timers.sv */
// Tick enable generator
// Single-cycle 1 MHz, 1 kHz and 10 Hz enables in the clk domain
`include "avionics_defines.svh"

module tick_timers (
  input  logic clk,
  input  logic rst_n,
  output logic tick_1mhz,
  output logic tick_1khz,
  output logic tick_10hz
);

  localparam int US_W = $clog2(`AV_CLK_PER_US);
  localparam int MS_W = $clog2(`AV_US_PER_MS);
  localparam int DS_W = $clog2(`AV_MS_PER_10HZ);

  // Terminal counts of each stage
  localparam logic [US_W-1:0] US_LAST = US_W'(`AV_CLK_PER_US - 1);
  localparam logic [MS_W-1:0] MS_LAST = MS_W'(`AV_US_PER_MS - 1);
  localparam logic [DS_W-1:0] DS_LAST = DS_W'(`AV_MS_PER_10HZ - 1);

  logic [US_W-1:0] us_cnt;
  logic [MS_W-1:0] ms_cnt;
  logic [DS_W-1:0] ds_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      us_cnt    <= '0;
      ms_cnt    <= '0;
      ds_cnt    <= '0;
      tick_1mhz <= 1'b0;
      tick_1khz <= 1'b0;
      tick_10hz <= 1'b0;
    end else begin
      // Stage 1: clk cycles per microsecond
      tick_1mhz <= (us_cnt == US_LAST);
      us_cnt    <= (us_cnt == US_LAST) ? '0 : us_cnt + 1'b1;

      // Stage 2 advances on the 1 MHz enable only
      tick_1khz <= tick_1mhz && (ms_cnt == MS_LAST);
      if (tick_1mhz) begin
        ms_cnt <= (ms_cnt == MS_LAST) ? '0 : ms_cnt + 1'b1;
      end

      // Stage 3 on the 1 kHz enable
      tick_10hz <= tick_1khz && (ds_cnt == DS_LAST);
      if (tick_1khz) begin
        ds_cnt <= (ds_cnt == DS_LAST) ? '0 : ds_cnt + 1'b1;
      end
    end
  end

endmodule

/* source/radio_capture.sv */
// Radio receiver pulse capture
// Per-channel synchronizer, edge detect and microsecond width counter
`include "avionics_defines.svh"

module radio_capture (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        tick_1mhz,
  input  logic                   [`AV_NUM_CH-1:0]     radio_sig,
  output avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0]     radio_width
);

  localparam avionics_pkg::pulse_us_t MAX_US = avionics_pkg::pulse_us_t'(`AV_PWM_MAX_US);

  // Two-flop synchronizer plus one stage for edges
  logic [`AV_NUM_CH-1:0] sync_1;
  logic [`AV_NUM_CH-1:0] sync_2;
  logic [`AV_NUM_CH-1:0] sync_prev;
  logic [`AV_NUM_CH-1:0] fall;

  // Running count of the current high pulse
  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0] high_cnt;

  // High last cycle, low now
  assign fall = sync_prev & ~sync_2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_1    <= '0;
      sync_2    <= '0;
      sync_prev <= '0;
    end else begin
      sync_1    <= radio_sig;
      sync_2    <= sync_1;
      sync_prev <= sync_2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      high_cnt    <= '0;
      radio_width <= '0;
    end else begin
      for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
        if (sync_2[ch]) begin
          // Count microseconds, hold at the ceiling
          if (tick_1mhz && (high_cnt[ch] != MAX_US)) begin
            high_cnt[ch] <= high_cnt[ch] + 1'b1;
          end
        end else begin
          high_cnt[ch] <= '0;
        end
        // Count is still intact in the falling-edge cycle
        if (fall[ch]) begin
          radio_width[ch] <= high_cnt[ch];
        end
      end
    end
  end

endmodule

/* source/esc_pwm.sv */
// ESC pulse generator
// Shared microsecond frame counter, widths latched once per frame
`include "avionics_defines.svh"

module esc_pwm (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        tick_1mhz,
  input  logic                                        enable,
  input  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0]     esc_width,
  output logic                   [`AV_NUM_CH-1:0]     esc_sig
);

  localparam int FW = $clog2(`AV_ESC_FRAME_US);
  localparam logic [FW-1:0] FRAME_LAST = FW'(`AV_ESC_FRAME_US - 1);

  // Microseconds into the current frame
  logic [FW-1:0] frame_us;
  logic          frame_end;

  // Widths held for the whole frame
  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0] width_q;

  assign frame_end = tick_1mhz && (frame_us == FRAME_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_us <= '0;
    end else if (frame_end) begin
      frame_us <= '0;
    end else if (tick_1mhz) begin
      frame_us <= frame_us + 1'b1;
    end
  end

  // New widths take effect as the counter returns to 0
  always_ff @(posedge clk) begin
    if (frame_end) begin
      width_q <= esc_width;
    end
  end

  // High from frame start for width_q microseconds
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      esc_sig <= '0;
    end else begin
      for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
        esc_sig[ch] <= enable && (frame_us < FW'(width_q[ch]));
      end
    end
  end

endmodule

/* source/arm_gesture.sv */
// Stick arm gesture detector
// 10 Hz sample of throttle low and yaw high, toggles armed on rising edge
`include "avionics_defines.svh"

module arm_gesture (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        tick_10hz,
  input  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0]     radio_width,
  input  logic                                        clear,
  output logic                                        armed
);

  localparam avionics_pkg::pulse_us_t THR_MAX =
    avionics_pkg::pulse_us_t'(`AV_ARM_THR_MAX);
  localparam avionics_pkg::pulse_us_t YAW_MIN =
    avionics_pkg::pulse_us_t'(`AV_ARM_YAW_MIN);

  logic gesture;
  logic sample_q;
  logic sample_prev;
  logic rise;

  // Throttle stick down, yaw stick fully right
  assign gesture = (radio_width[`AV_THR_CH] < THR_MAX) &&
                   (radio_width[`AV_YAW_CH] > YAW_MIN);

  // Edge of the sampled condition, not of the raw sticks
  assign rise = sample_q && !sample_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample_q    <= 1'b0;
      sample_prev <= 1'b0;
      armed       <= 1'b0;
    end else begin
      if (tick_10hz) begin
        sample_q <= gesture;
      end
      sample_prev <= sample_q;
      // Clear wins over a toggle in the same cycle
      if (clear) begin
        armed <= 1'b0;
      end else if (rise) begin
        armed <= !armed;
      end
    end
  end

endmodule

/* source/board_control.sv */
// Board controller
// IDLE, STARTUP, RUNNING, SHUTDOWN sequence and millisecond timestamp
`include "avionics_defines.svh"

module board_control (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tick_1khz,
  input  logic                armed_in,
  board_status_if.ctrl        status,
  output logic                arm_clear
);

  avionics_pkg::board_state_e state_q;
  avionics_pkg::board_state_e state_d;
  logic [23:0]                timestamp_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Nothing to wait for yet
      avionics_pkg::IDLE:     state_d = avionics_pkg::STARTUP;
      avionics_pkg::STARTUP:  state_d = avionics_pkg::RUNNING;
      // Stay until the host asks to stop
      avionics_pkg::RUNNING: begin
        if (status.shutdown_req) begin
          state_d = avionics_pkg::SHUTDOWN;
        end
      end
      avionics_pkg::SHUTDOWN: state_d = avionics_pkg::IDLE;
      default:                state_d = avionics_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= avionics_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Milliseconds since entering RUNNING, zero elsewhere
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timestamp_q <= '0;
    end else if (state_q != avionics_pkg::RUNNING) begin
      timestamp_q <= '0;
    end else if (tick_1khz) begin
      timestamp_q <= timestamp_q + 1'b1;
    end
  end

  // Motors disarm whenever the board leaves RUNNING
  assign arm_clear = (state_q != avionics_pkg::RUNNING);

  // Status out to the register block
  assign status.state     = state_q;
  assign status.armed     = armed_in;
  assign status.timestamp = timestamp_q;

endmodule

/* source/apb_status_regs.sv */
// APB slave for host access
// STATUS, TIME, CTRL and per-channel radio width registers
`include "avionics_defines.svh"

module apb_status_regs (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                   [`AV_APB_AW-1:0]     paddr,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic                   [`AV_APB_DW-1:0]     pwdata,
  output logic                   [`AV_APB_DW-1:0]     prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  input  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0]     radio_width,
  board_status_if.regs                                status
);

  localparam int AW   = `AV_APB_AW;
  localparam int DW   = `AV_APB_DW;
  localparam int CH_W = $clog2(`AV_NUM_CH);

  logic          setup;
  logic          access;
  logic [AW-1:0] radio_off;
  logic [CH_W-1:0] radio_idx;
  logic          hit_status;
  logic          hit_time;
  logic          hit_ctrl;
  logic          hit_radio;
  logic          bad;
  logic [DW-1:0] rdata;

  // APB phases
  assign setup  = psel && !penable;
  assign access = psel && penable;

  // Radio block: word aligned, one word per channel
  assign radio_off = paddr - AW'(`AV_ADDR_RADIO0);
  assign radio_idx = radio_off[2 +: CH_W];
  assign hit_radio = (radio_off[1:0] == 2'b00) &&
                     (radio_off[AW-1:2] < (AW-2)'(`AV_NUM_CH));

  assign hit_status = (paddr == AW'(`AV_ADDR_STATUS));
  assign hit_time   = (paddr == AW'(`AV_ADDR_TIME));
  assign hit_ctrl   = (paddr == AW'(`AV_ADDR_CTRL));

  // Unmapped, or a write to anything but CTRL
  assign bad = !(hit_status || hit_time || hit_ctrl || hit_radio) ||
               (pwrite && !hit_ctrl);

  // Read mux, CTRL reads as zero
  always_comb begin
    rdata = '0;
    if (hit_status) begin
      rdata = DW'({status.armed, status.state});
    end else if (hit_time) begin
      rdata = DW'(status.timestamp);
    end else if (hit_radio) begin
      rdata = DW'(radio_width[radio_idx]);
    end
  end

  // Captured in setup so data and error are ready in the access cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prdata              <= '0;
      pslverr             <= 1'b0;
      status.shutdown_req <= 1'b0;
    end else begin
      pslverr <= setup && bad;
      if (setup && !pwrite) begin
        prdata <= rdata;
      end
      // Single pulse per CTRL write with bit 0 set
      status.shutdown_req <= access && pwrite && hit_ctrl && pwdata[0];
    end
  end

  // Never stalls
  assign pready = 1'b1;

endmodule

/* source/avionics_top.sv */
// Flight-control board top level
// Tick timers, radio capture, arm gesture, board FSM, ESC PWM and APB regs
`include "avionics_defines.svh"

module avionics_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`AV_NUM_CH-1:0] radio_sig,
  output logic [`AV_NUM_CH-1:0] esc_sig,
  input  logic [`AV_APB_AW-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`AV_APB_DW-1:0] pwdata,
  output logic [`AV_APB_DW-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  logic tick_1mhz;
  logic tick_1khz;
  logic tick_10hz;
  logic armed;
  logic arm_clear;
  logic esc_enable;

  avionics_pkg::pulse_us_t [`AV_NUM_CH-1:0] radio_width;

  board_status_if status_if ();

  tick_timers u_tick_timers (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick_1mhz (tick_1mhz),
    .tick_1khz (tick_1khz),
    .tick_10hz (tick_10hz)
  );

  radio_capture u_radio_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .tick_1mhz   (tick_1mhz),
    .radio_sig   (radio_sig),
    .radio_width (radio_width)
  );

  arm_gesture u_arm_gesture (
    .clk         (clk),
    .rst_n       (rst_n),
    .tick_10hz   (tick_10hz),
    .radio_width (radio_width),
    .clear       (arm_clear),
    .armed       (armed)
  );

  board_control u_board_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick_1khz (tick_1khz),
    .armed_in  (armed),
    .status    (status_if.ctrl),
    .arm_clear (arm_clear)
  );

  // Motors spin only when running and armed
  assign esc_enable = (status_if.state == avionics_pkg::RUNNING) && status_if.armed;

  // ESC commands follow the radio directly
  esc_pwm u_esc_pwm (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick_1mhz (tick_1mhz),
    .enable    (esc_enable),
    .esc_width (radio_width),
    .esc_sig   (esc_sig)
  );

  apb_status_regs u_apb_status_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .radio_width (radio_width),
    .status      (status_if.regs)
  );

endmodule

/* verif/avionics_tb.sv */
// Testbench for the flight-control board top level
// Radio pulse generator, ESC pulse meter, APB tasks and a row table
`include "avionics_defines.svh"

module avionics_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS  = 6;
  localparam int FRAME_CYC = `AV_ESC_FRAME_US * `AV_CLK_PER_US;
  // Radio frames, more than one 10 Hz period of 40 frames
  localparam int HOLD_FRAMES = 45;

  logic                  clk;
  logic                  rst_n;
  logic [`AV_NUM_CH-1:0] radio_sig;
  logic [`AV_NUM_CH-1:0] esc_sig;
  logic [`AV_APB_AW-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`AV_APB_DW-1:0] pwdata;
  logic [`AV_APB_DW-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // Generator widths, frame count and ESC meter state
  int radio_us [`AV_NUM_CH];
  int radio_frames;
  int esc_count [`AV_NUM_CH];
  int esc_meas [`AV_NUM_CH];
  int esc_pulses [`AV_NUM_CH];

  // Row table: radio widths, expected armed, expected ESC activity
  int row_width [NUM_ROWS][`AV_NUM_CH];
  bit row_armed [NUM_ROWS];
  bit row_esc [NUM_ROWS];
  logic [31:0] rng;

  avionics_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .radio_sig (radio_sig),
    .esc_sig   (esc_sig),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Radio frames, all channels rise together
  initial begin
    int snap [`AV_NUM_CH];
    logic [`AV_NUM_CH-1:0] next_sig;
    forever begin
      for (int ch = 0; ch < `AV_NUM_CH; ch++) snap[ch] = radio_us[ch];
      for (int cyc = 0; cyc < FRAME_CYC; cyc++) begin
        @(posedge clk);
        for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
          next_sig[ch] = (cyc < snap[ch] * `AV_CLK_PER_US);
        end
        radio_sig <= next_sig;
      end
      radio_frames++;
    end
  end

  // ESC meter, high cycles per pulse in microseconds
  initial begin
    forever begin
      @(negedge clk);
      for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
        if (esc_sig[ch] === 1'b1) begin
          esc_count[ch]++;
        end else if (esc_count[ch] != 0) begin
          esc_meas[ch] = esc_count[ch] / `AV_CLK_PER_US;
          esc_pulses[ch]++;
          esc_count[ch] = 0;
        end
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Equal within tol, values shown in hex, unknown bits never match
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int tol);
    int diff;
    diff = int'(got) - int'(exp);
    if ($isunknown(got) || diff > tol || diff < -tol) begin
      report_failure($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Setup then access, sampled mid-cycle
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (pready !== 1'b1) begin
      if (waited == 16) report_failure("Timeout waiting for pready on APB");
      waited++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_value("pslverr", err, 0, 0);
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic err;
    apb_access(1'b1, addr, data, unused, err);
    check_value("pslverr", err, 0, 0);
  endtask

  // STATUS holds state in 1:0, armed in 2
  task automatic read_status(output logic [1:0] state, output logic armed);
    logic [31:0] data;
    apb_read(`AV_ADDR_STATUS, data);
    state = data[1:0];
    armed = data[2];
  endtask

  task automatic wait_running();
    logic [1:0] state;
    logic armed;
    int polls;
    polls = 0;
    read_status(state, armed);
    while (state != avionics_pkg::RUNNING) begin
      if (polls == 20) begin
        report_failure("Timeout waiting for the board to reach RUNNING");
      end else begin
        polls++;
        read_status(state, armed);
      end
    end
  endtask

  task automatic wait_frames(input int n);
    int start;
    int waited;
    start  = radio_frames;
    waited = 0;
    while (radio_frames - start < n) begin
      @(negedge clk);
      waited++;
      if (waited > (n + 2) * FRAME_CYC) report_failure("Timeout waiting for radio frames");
    end
  endtask

  // Every channel completes n more ESC pulses
  task automatic wait_esc_pulses(input int n);
    int start [`AV_NUM_CH];
    int waited;
    bit done;
    for (int ch = 0; ch < `AV_NUM_CH; ch++) start[ch] = esc_pulses[ch];
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      waited++;
      done = 1'b1;
      for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
        if (esc_pulses[ch] - start[ch] < n) done = 1'b0;
      end
      if (!done && waited > (n + 2) * FRAME_CYC) report_failure("Timeout waiting for ESC pulses");
    end
  endtask

  // One full ESC frame with every output low
  task automatic check_esc_quiet();
    repeat (FRAME_CYC + 4 * `AV_CLK_PER_US) begin
      @(negedge clk);
      check_value("esc_sig", esc_sig, 0, 0);
    end
  endtask

  // Other channels random in 1000 to 2000
  task automatic set_row(input int r, input int thr, input int yaw,
                         input bit armed, input bit esc);
    for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
      rng = xorshift32(rng);
      row_width[r][ch] = 1000 + int'(rng % 1001);
    end
    row_width[r][`AV_THR_CH] = thr;
    row_width[r][`AV_YAW_CH] = yaw;
    row_armed[r] = armed;
    row_esc[r]   = esc;
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [1:0]  state;
    logic        armed;
    logic        err;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    radio_sig = '0;
    rng       = 32'd23451;
    // Centered, gesture arms, release holds, gesture again disarms
    set_row(0, 1500, 1500, 1'b0, 1'b0);
    set_row(1, 1000, 2000, 1'b1, 1'b1);
    set_row(2, 1500, 1500, 1'b1, 1'b1);
    set_row(3, 1000, 2000, 1'b0, 1'b0);
    // Release, then arm once more ahead of the shutdown
    set_row(4, 1500, 1500, 1'b0, 1'b0);
    set_row(5, 1000, 2000, 1'b1, 1'b1);
    // Live widths from the start, a wrong ESC enable would show
    for (int ch = 0; ch < `AV_NUM_CH; ch++) radio_us[ch] = row_width[0][ch];
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Board comes up on its own, motors off
    wait_running();
    read_status(state, armed);
    check_value("armed", armed, 0, 0);
    // Widths captured and latched by the ESC frame first
    wait_frames(3);
    check_esc_quiet();

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk);
      for (int ch = 0; ch < `AV_NUM_CH; ch++) radio_us[ch] = row_width[r][ch];
      wait_frames(HOLD_FRAMES);
      for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
        apb_read(`AV_ADDR_RADIO0 + 4 * ch, data);
        check_value($sformatf("radio_width[%0d]", ch), data, row_width[r][ch], 1);
      end
      read_status(state, armed);
      check_value("armed", armed, row_armed[r], 0);
      if (row_esc[r]) begin
        wait_esc_pulses(2);
        for (int ch = 0; ch < `AV_NUM_CH; ch++) begin
          check_value($sformatf("esc_width[%0d]", ch), esc_meas[ch], row_width[r][ch], 3);
        end
      end else begin
        check_esc_quiet();
      end
    end

    // About 5 ms between TIME reads
    apb_read(`AV_ADDR_TIME, t0);
    repeat (5 * `AV_US_PER_MS * `AV_CLK_PER_US) @(posedge clk);
    apb_read(`AV_ADDR_TIME, t1);
    check_value("time_delta", t1 - t0, 5, 1);

    // Shutdown while armed restarts the board disarmed with a fresh timestamp
    apb_write(`AV_ADDR_CTRL, 32'h1);
    wait_running();
    read_status(state, armed);
    check_value("armed", armed, 0, 0);
    apb_read(`AV_ADDR_TIME, data);
    check_value("timestamp", data, 0, 1);

    // Unmapped read and STATUS write
    apb_access(1'b0, 8'h40, 32'h0, data, err);
    check_value("pslverr", err, 1, 0);
    apb_access(1'b1, `AV_ADDR_STATUS, 32'h1, data, err);
    check_value("pslverr", err, 1, 0);

    $display(">>> PASS");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
source/avionics_pkg.sv
source/board_status_if.sv
source/tick_timers.sv
source/radio_capture.sv
source/esc_pwm.sv
source/arm_gesture.sv
source/board_control.sv
source/apb_status_regs.sv
source/avionics_top.sv
verif/avionics_tb.sv
